// File: design/hif_bridge.sv
`timescale 1ns/10ps
`include "hif_cfg.svh"

module hif_bridge (
  input  logic                                  host_clk,
  input  logic                                  reset,
  // host bus
  input  logic                                  wb_cyc,
  input  logic                                  wb_stb,
  input  logic                                  wb_we,
  input  hif_pkg::wb_addr_t                     wb_adr,
  input  hif_pkg::data_t                        wb_dat_w,
  output logic                                  wb_ack,
  output hif_pkg::data_t                        wb_dat_r,
  // core side, one slot per channel
  output logic [`HIF_NUM_CHAN-1:0]              in_valid,
  input  logic [`HIF_NUM_CHAN-1:0]              in_ready,
  output hif_pkg::data_t [`HIF_NUM_CHAN-1:0]    in_data,
  input  logic [`HIF_NUM_CHAN-1:0]              out_valid,
  output logic [`HIF_NUM_CHAN-1:0]              out_ready,
  input  hif_pkg::data_t [`HIF_NUM_CHAN-1:0]    out_data,
  output logic                                  core_reset
);

  logic [`HIF_NUM_CHAN-1:0]              push;
  logic [`HIF_NUM_CHAN-1:0]              pop;
  logic [`HIF_NUM_CHAN-1:0]              in_full;
  logic                                  rd_load;
  hif_pkg::chan_idx_t                    rd_chan;
  logic [1:0]                            rd_reg;
  hif_pkg::count_t [`HIF_NUM_CHAN-1:0]   in_count;
  hif_pkg::count_t [`HIF_NUM_CHAN-1:0]   out_count;
  hif_pkg::data_t  [`HIF_NUM_CHAN-1:0]   out_head;

  wb_reg_slave u_slave (
    .host_clk   (host_clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_ack     (wb_ack),
    .in_full    (in_full),
    .push       (push),
    .pop        (pop),
    .rd_load    (rd_load),
    .rd_chan    (rd_chan),
    .rd_reg     (rd_reg),
    .core_reset (core_reset)
  );

  for (genvar c = 0; c < `HIF_NUM_CHAN; c++)
  begin : g_chan
    hif_channel u_chan (
      .host_clk  (host_clk),
      .reset     (reset),
      .push      (push[c]),
      .push_data (wb_dat_w),  // every channel sees the bus word
      .pop       (pop[c]),
      .in_full   (in_full[c]),
      .in_valid  (in_valid[c]),
      .in_ready  (in_ready[c]),
      .in_data   (in_data[c]),
      .out_valid (out_valid[c]),
      .out_ready (out_ready[c]),
      .out_data  (out_data[c]),
      .out_head  (out_head[c]),
      .in_count  (in_count[c]),
      .out_count (out_count[c])
    );
  end

  hif_read_mux u_rd_mux (
    .host_clk  (host_clk),
    .reset     (reset),
    .rd_load   (rd_load),
    .rd_chan   (rd_chan),
    .rd_reg    (rd_reg),
    .in_count  (in_count),
    .out_count (out_count),
    .out_head  (out_head),
    .wb_dat_r  (wb_dat_r)
  );

endmodule

// File: design/hif_channel.sv
`timescale 1ns/10ps
`include "hif_cfg.svh"

module hif_channel (
  input  logic             host_clk,
  input  logic             reset,
  // host side, strobes from the register slave
  input  logic             push,
  input  hif_pkg::data_t   push_data,
  input  logic             pop,
  output logic             in_full,
  // core side, inbound
  output logic             in_valid,
  input  logic             in_ready,
  output hif_pkg::data_t   in_data,
  // core side, outbound
  input  logic             out_valid,
  output logic             out_ready,
  input  hif_pkg::data_t   out_data,
  // status for the read mux
  output hif_pkg::data_t   out_head,
  output hif_pkg::count_t  in_count,
  output hif_pkg::count_t  out_count
);

  // queue 0 is inbound (host to core), queue 1 is outbound (core to host)
  logic [1:0]       q_wr;
  logic [1:0]       q_rd;
  hif_pkg::data_t   q_din [2];
  hif_pkg::data_t   q_head [2];
  hif_pkg::count_t  q_cnt [2];

  // inbound fill and drain
  assign q_wr[0]  = push;  // fullness already checked by the slave
  assign q_din[0] = push_data;
  assign q_rd[0]  = in_valid && in_ready;

  // outbound fill and drain
  assign q_wr[1]  = out_valid && out_ready;
  assign q_din[1] = out_data;
  assign q_rd[1]  = pop && (out_count != '0);  // pop of empty queue ignored

  for (genvar q = 0; q < 2; q++)
  begin : g_q
    hif_pkg::data_t          mem [`HIF_FIFO_DEPTH];
    logic [`HIF_PTR_W-1:0]   rd_ptr;
    logic [`HIF_PTR_W-1:0]   wr_ptr;
    hif_pkg::count_t         cnt;

    always_ff @(posedge host_clk)
    begin
      if (reset)
      begin
        rd_ptr <= '0;
        wr_ptr <= '0;
        cnt    <= '0;
      end
      else
      begin
        if (q_wr[q])
          wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
        if (q_rd[q])
          rd_ptr <= rd_ptr + 1'b1;
        if (q_wr[q] != q_rd[q])
          cnt <= q_wr[q] ? cnt + 1'b1 : cnt - 1'b1;
      end
    end

    // storage
    always_ff @(posedge host_clk)
    begin
      if (q_wr[q])
        mem[wr_ptr] <= q_din[q];
    end

    assign q_head[q] = mem[rd_ptr];  // fall-through head
    assign q_cnt[q]  = cnt;
  end

  assign in_count  = q_cnt[0];
  assign out_count = q_cnt[1];

  assign in_full   = (q_cnt[0] == hif_pkg::count_t'(`HIF_FIFO_DEPTH));
  assign in_valid  = (q_cnt[0] != '0);
  assign in_data   = q_head[0];

  // outbound space left
  assign out_ready = (q_cnt[1] != hif_pkg::count_t'(`HIF_FIFO_DEPTH));
  assign out_head  = q_head[1];

endmodule

// File: design/hif_pkg.sv
`include "hif_cfg.svh"

package hif_pkg;

  typedef logic [`HIF_DATA_W-1:0] data_t;     // bus word and queue entry
  typedef logic [`HIF_ADDR_W-1:0] wb_addr_t;  // wishbone word address
  typedef logic [`HIF_CNT_W-1:0]  count_t;    // queue occupancy
  typedef logic [`HIF_CHAN_W-1:0] chan_idx_t;

  // wishbone slave states
  typedef enum logic [1:0] {
    IDLE,
    WR_WAIT,
    ACK
  } wb_state_t;

endpackage

// File: design/hif_read_mux.sv
`timescale 1ns/10ps
`include "hif_cfg.svh"

module hif_read_mux (
  input  logic                                   host_clk,
  input  logic                                   reset,
  input  logic                                   rd_load,
  input  hif_pkg::chan_idx_t                     rd_chan,
  input  logic [1:0]                             rd_reg,
  input  hif_pkg::count_t [`HIF_NUM_CHAN-1:0]    in_count,
  input  hif_pkg::count_t [`HIF_NUM_CHAN-1:0]    out_count,
  input  hif_pkg::data_t  [`HIF_NUM_CHAN-1:0]    out_head,
  output hif_pkg::data_t                         wb_dat_r
);

  hif_pkg::data_t  sel_data;

  // offset select for the addressed channel
  always_comb
  begin
    case (rd_reg)
      `HIF_REG_DATA:
        sel_data = hif_pkg::data_t'(out_count[rd_chan]);  // zero extended
      `HIF_REG_POP:
        sel_data = out_head[rd_chan];
      `HIF_REG_INCNT:
        sel_data = hif_pkg::data_t'(in_count[rd_chan]);
      default:
        sel_data = '0;  // unmapped reads
    endcase
  end

  // loaded on accept, held through the ack cycle
  always_ff @(posedge host_clk)
  begin
    if (reset)
      wb_dat_r <= '0;
    else if (rd_load)
      wb_dat_r <= sel_data;
  end

endmodule

// File: design/wb_reg_slave.sv
`timescale 1ns/10ps
`include "hif_cfg.svh"

module wb_reg_slave (
  input  logic                      host_clk,
  input  logic                      reset,
  // wishbone classic
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  hif_pkg::wb_addr_t         wb_adr,
  output logic                      wb_ack,
  // channel strobes
  input  logic [`HIF_NUM_CHAN-1:0]  in_full,
  output logic [`HIF_NUM_CHAN-1:0]  push,
  output logic [`HIF_NUM_CHAN-1:0]  pop,
  // read mux control
  output logic                      rd_load,
  output hif_pkg::chan_idx_t        rd_chan,
  output logic [1:0]                rd_reg,
  output logic                      core_reset
);

  hif_pkg::wb_state_t  state;

  logic                req;
  logic                adr_mapped;  // address falls in some channel window
  hif_pkg::chan_idx_t  adr_chan;
  logic [1:0]          adr_reg;
  logic                data_wr;

  // request decode kept for WR_WAIT and ACK
  logic                req_we;
  hif_pkg::chan_idx_t  req_chan;
  logic                req_pop;
  logic                req_rst;

  assign req        = wb_cyc && wb_stb;
  assign adr_mapped = (wb_adr[`HIF_ADDR_W-1:2] < `HIF_NUM_CHAN);
  assign adr_chan   = wb_adr[2 +: `HIF_CHAN_W];
  assign adr_reg    = wb_adr[1:0];
  assign data_wr    = wb_we && adr_mapped && (adr_reg == `HIF_REG_DATA);

  always_ff @(posedge host_clk)
  begin
    if (reset)
      state <= hif_pkg::IDLE;
    else
    begin
      case (state)
        hif_pkg::IDLE:
          if (req)
          begin
            if (data_wr && in_full[adr_chan])
              state <= hif_pkg::WR_WAIT;  // hold the bus until space
            else
              state <= hif_pkg::ACK;
          end
        hif_pkg::WR_WAIT:
          if (!in_full[req_chan])
            state <= hif_pkg::ACK;
        default:
          state <= hif_pkg::IDLE;  // ack lasts one cycle
      endcase
    end
  end

  always_ff @(posedge host_clk)
  begin
    if (state == hif_pkg::IDLE && req)
    begin
      req_we   <= wb_we;
      req_chan <= adr_chan;
      req_pop  <= adr_mapped && (adr_reg == `HIF_REG_POP);
      req_rst  <= (wb_adr == `HIF_RESET_ADDR);
    end
  end

  // push as the slave moves to ACK, pop during the ack of a pop read
  always_comb
  begin
    push = '0;
    pop  = '0;
    if (state == hif_pkg::IDLE && req && data_wr && !in_full[adr_chan])
      push[adr_chan] = 1'b1;
    if (state == hif_pkg::WR_WAIT && !in_full[req_chan])
      push[req_chan] = 1'b1;
    if (state == hif_pkg::ACK && !req_we && req_pop)
      pop[req_chan] = 1'b1;
  end

  // read data is captured on the accept edge
  assign rd_load = (state == hif_pkg::IDLE) && req && !wb_we;
  assign rd_chan = adr_chan;
  assign rd_reg  = adr_mapped ? adr_reg : `HIF_REG_NONE;

  assign wb_ack     = (state == hif_pkg::ACK);
  assign core_reset = (state == hif_pkg::ACK) && req_we && req_rst;

endmodule

// File: include/hif_cfg.svh
`ifndef HIF_CFG_SVH
`define HIF_CFG_SVH

// channel count and its index width, keep the two in step
`define HIF_NUM_CHAN    2
`define HIF_CHAN_W      1

`define HIF_FIFO_DEPTH  32  // power of two
`define HIF_PTR_W       5   // log2 of the depth
`define HIF_CNT_W       6   // holds 0 .. depth

`define HIF_DATA_W      32
`define HIF_ADDR_W      5   // word address

// offsets inside a channel's 4-word window, channel c at word 4c
`define HIF_REG_DATA    2'd0  // wr push inbound, rd outbound count
`define HIF_REG_POP     2'd1  // rd pops outbound
`define HIF_REG_INCNT   2'd2  // rd inbound count
`define HIF_REG_NONE    2'd3  // reads as zero

`define HIF_RESET_ADDR  5'h1f

`endif

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module hif_tb -o hif_sim

out=$(./obj_dir/hif_sim)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"

// File: src.f
+incdir+include
design/hif_pkg.sv
design/hif_channel.sv
design/wb_reg_slave.sv
design/hif_read_mux.sv
design/hif_bridge.sv
tests/hif_bridge_checker.sv
tests/hif_clk_gen.sv
tests/hif_monitor.sv
tests/hif_tb.sv

// File: tests/hif_bridge_checker.sv
`timescale 1ns/10ps
`include "hif_cfg.svh"

module hif_bridge_checker (
  input logic                      host_clk,
  input logic                      reset,
  input logic                      wb_cyc,
  input logic                      wb_stb,
  input logic                      wb_ack,
  input logic [`HIF_NUM_CHAN-1:0]  push,
  input logic [`HIF_NUM_CHAN-1:0]  in_full,
  input logic                      core_reset
);

  // ack is a single-cycle pulse
  ack_single: assert property (@(posedge host_clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("ack high two cycles in a row");

  ack_in_cycle: assert property (@(posedge host_clk) disable iff (reset)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("ack outside a bus cycle");

  no_push_full: assert property (@(posedge host_clk) disable iff (reset)
    (push & in_full) == '0)
    else $error("push into a full inbound queue");

  // core reset pulse is one cycle long
  rst_pulse: assert property (@(posedge host_clk) disable iff (reset)
    core_reset |=> !core_reset)
    else $error("core reset longer than one cycle");

endmodule

bind wb_reg_slave hif_bridge_checker u_chk (
  .host_clk   (host_clk),
  .reset      (reset),
  .wb_cyc     (wb_cyc),
  .wb_stb     (wb_stb),
  .wb_ack     (wb_ack),
  .push       (push),
  .in_full    (in_full),
  .core_reset (core_reset)
);

// File: tests/hif_clk_gen.sv
`timescale 1ns/10ps

module hif_clk_gen (
  output logic host_clk,
  output logic reset
);

  initial
  begin
    host_clk = 1'b0;
    forever
      #2 host_clk = ~host_clk;  // 4 ns period
  end

  // held over the first three rising edges
  initial
  begin
    reset = 1'b1;
    repeat (3) @(posedge host_clk);
    reset <= 1'b0;
  end

endmodule

// File: tests/hif_monitor.sv
`timescale 1ns/10ps
`include "hif_cfg.svh"

module hif_monitor (
  input logic                                host_clk,
  input logic                                reset,
  input logic                                wb_ack,
  input logic                                wb_we,
  input hif_pkg::data_t                      wb_dat_r,
  input logic [`HIF_NUM_CHAN-1:0]            in_valid,
  input logic [`HIF_NUM_CHAN-1:0]            in_ready,
  input hif_pkg::data_t [`HIF_NUM_CHAN-1:0]  in_data,
  input logic                                core_reset
);

  hif_pkg::data_t  in_exp [`HIF_NUM_CHAN][$];  // words the core should take
  hif_pkg::data_t  rd_exp [$];
  string           rd_name [$];
  int              value_errs = 0;
  int              other_errs = 0;
  int              rst_cycles = 0;

  task automatic check_value(input string name, input hif_pkg::data_t exp,
                             input hif_pkg::data_t act);
    if (exp !== act)
    begin
      $display("** Error [%s] expected %h actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic expect_in(input int c, input hif_pkg::data_t w);
    in_exp[c].push_back(w);
  endtask

  task automatic expect_read(input string name, input hif_pkg::data_t w);
    rd_exp.push_back(w);
    rd_name.push_back(name);
  endtask

  always @(posedge host_clk)
  begin
    if (!reset)
    begin
      for (int c = 0; c < `HIF_NUM_CHAN; c++)
      begin
        if (in_valid[c] && in_ready[c])
        begin
          if (in_exp[c].size() == 0)
          begin
            $display("core took a word on channel %0d that was never written", c);
            other_errs++;
          end
          else
            check_value($sformatf("core_in_ch%0d", c), in_exp[c].pop_front(), in_data[c]);
        end
      end
      if (wb_ack && !wb_we)
      begin
        if (rd_exp.size() == 0)
        begin
          $display("read acked with no read pending");
          other_errs++;
        end
        else
          check_value(rd_name.pop_front(), rd_exp.pop_front(), wb_dat_r);
      end
      if (core_reset)
      begin
        rst_cycles++;
        if (!wb_ack)
        begin
          $display("core reset outside the ack cycle");
          other_errs++;
        end
      end
    end
  end

  function automatic int total_errors();
    return value_errs + other_errs;
  endfunction

  task automatic report();
    for (int c = 0; c < `HIF_NUM_CHAN; c++)
    begin
      if (in_exp[c].size() != 0)
      begin
        $display("channel %0d still owes the core %0d words", c, in_exp[c].size());
        other_errs++;
      end
    end
    $display("errors: %0d value, %0d other", value_errs, other_errs);
  endtask

endmodule

// File: tests/hif_tb.sv
`timescale 1ns/10ps
`include "hif_cfg.svh"

module hif_tb;

  localparam int NCH         = `HIF_NUM_CHAN;
  localparam int NUM_RAND_WR = 40;  // host writes in the random mix
  localparam int MAX_BURST   = 11;  // most core pushes per channel
  // bus and core transfers summed over all tests
  localparam int NUM_TRANS   = 2 * NCH                      // reset count reads
                             + NUM_RAND_WR
                             + NCH * (2 * MAX_BURST + 2)    // pushes and pops with two count reads
                             + NCH * (NCH + 3)              // idle core writes and count reads
                             + `HIF_FIFO_DEPTH + 1          // fill and the stalled write
                             + 5                            // core reset test
                             + 4;                           // drains

  logic                            host_clk;
  logic                            reset;
  logic                            wb_cyc;
  logic                            wb_stb;
  logic                            wb_we;
  hif_pkg::wb_addr_t               wb_adr;
  hif_pkg::data_t                  wb_dat_w;
  logic                            wb_ack;
  hif_pkg::data_t                  wb_dat_r;
  logic [NCH-1:0]                  in_valid;
  logic [NCH-1:0]                  in_ready = '0;
  hif_pkg::data_t [NCH-1:0]        in_data;
  logic [NCH-1:0]                  out_valid;
  logic [NCH-1:0]                  out_ready;
  hif_pkg::data_t [NCH-1:0]        out_data;
  logic                            core_reset;

  logic [1:0]      ready_mode [NCH] = '{default: 2'd0};  // 0 low, 1 random, 2 high
  int              written [NCH] = '{default: 0};
  int              taken [NCH] = '{default: 0};
  hif_pkg::data_t  out_model [NCH][$];

  hif_clk_gen u_clk (.host_clk(host_clk), .reset(reset));

  hif_bridge u_dut (.*);

  hif_monitor u_mon (
    .host_clk   (host_clk),
    .reset      (reset),
    .wb_ack     (wb_ack),
    .wb_we      (wb_we),
    .wb_dat_r   (wb_dat_r),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .core_reset (core_reset)
  );

  // core side ready
  always @(posedge host_clk)
  begin
    for (int c = 0; c < NCH; c++)
    begin
      case (ready_mode[c])
        2'd1: in_ready[c] <= logic'($urandom & 1);
        2'd2: in_ready[c] <= 1'b1;
        default: in_ready[c] <= 1'b0;
      endcase
    end
  end

  always @(posedge host_clk)
  begin
    if (!reset)
      for (int c = 0; c < NCH; c++)
        if (in_valid[c] && in_ready[c])
          taken[c] = taken[c] + 1;
  end

  function automatic hif_pkg::wb_addr_t reg_addr(input int c, input int r);
    return hif_pkg::wb_addr_t'(c * 4 + r);
  endfunction

  // expected register value from the model queues
  function automatic hif_pkg::data_t ref_read(input int c, input int r);
    case (r)
      0: return hif_pkg::data_t'(out_model[c].size());
      1: return out_model[c][0];
      2: return hif_pkg::data_t'(written[c] - taken[c]);
      default: return '0;
    endcase
  endfunction

  task automatic bus_cycle(input hif_pkg::wb_addr_t adr, input logic we,
                           input hif_pkg::data_t w);
    @(posedge host_clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= w;
    @(posedge host_clk);
    while (!wb_ack)
      @(posedge host_clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_word(input int c, input hif_pkg::data_t w);
    u_mon.expect_in(c, w);
    written[c] = written[c] + 1;
    bus_cycle(reg_addr(c, 0), 1'b1, w);
  endtask

  task automatic read_check(input string name, input int c, input int r);
    u_mon.expect_read(name, ref_read(c, r));
    bus_cycle(reg_addr(c, r), 1'b0, '0);
    if (r == 1)
      void'(out_model[c].pop_front());
  endtask

  task automatic core_push(input int c, input hif_pkg::data_t w);
    @(posedge host_clk);
    out_valid[c] <= 1'b1;
    out_data[c]  <= w;
    @(posedge host_clk);
    while (!out_ready[c])
      @(posedge host_clk);
    out_valid[c] <= 1'b0;
    out_model[c].push_back(w);
  endtask

  task automatic drain();
    @(posedge host_clk);
    for (int c = 0; c < NCH; c++)
      ready_mode[c] <= 2'd1;
    @(posedge host_clk);
    while (in_valid != '0)
      @(posedge host_clk);
    for (int c = 0; c < NCH; c++)
      ready_mode[c] <= 2'd0;
    repeat (2) @(posedge host_clk);
  endtask

  initial
  begin
    int n;
    void'($urandom(32'hc7e7_281a));
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    out_valid = '0;
    out_data  = '0;
    @(posedge host_clk);
    while (reset)
      @(posedge host_clk);

    // reset values
    u_mon.check_value("reset_ack", '0, hif_pkg::data_t'(wb_ack));
    u_mon.check_value("reset_core_reset", '0, hif_pkg::data_t'(core_reset));
    u_mon.check_value("reset_in_valid", '0, hif_pkg::data_t'(in_valid));
    u_mon.check_value("reset_out_ready", hif_pkg::data_t'({NCH{1'b1}}),
                      hif_pkg::data_t'(out_ready));
    for (int c = 0; c < NCH; c++)
    begin
      read_check("reset_out_count", c, 0);
      read_check("reset_in_count", c, 2);
    end

    // random writes, random core takes
    for (int c = 0; c < NCH; c++)
      ready_mode[c] <= 2'd1;
    for (int i = 0; i < NUM_RAND_WR; i++)
      write_word(int'($urandom % NCH), $urandom);
    drain();

    // core to host
    for (int c = 0; c < NCH; c++)
    begin
      n = 4 + int'($urandom % (MAX_BURST - 3));
      for (int i = 0; i < n; i++)
        core_push(c, $urandom);
      read_check("out_count", c, 0);
      for (int i = 0; i < n; i++)
        read_check("out_pop", c, 1);
      read_check("out_count_empty", c, 0);
    end

    // inbound count with the core idle
    for (int c = 0; c < NCH; c++)
      for (int i = 0; i < 3 + c * 2; i++)
        write_word(c, $urandom);
    for (int c = 0; c < NCH; c++)
      read_check("in_count", c, 2);
    drain();

    // full inbound queue stalls the bus
    for (int i = 0; i < `HIF_FIFO_DEPTH; i++)
      write_word(0, $urandom);
    fork
      write_word(0, 32'hfeed_0033);
      begin
        repeat (20)
        begin
          @(posedge host_clk);
          u_mon.check_value("full_stall_ack", '0, hif_pkg::data_t'(wb_ack));
        end
        ready_mode[0] <= 2'd2;  // exactly one take
        @(posedge host_clk);
        ready_mode[0] <= 2'd0;
      end
    join
    drain();

    // core reset write leaves the counts alone
    write_word(1, $urandom);
    write_word(1, $urandom);
    bus_cycle(`HIF_RESET_ADDR, 1'b1, '0);
    repeat (2) @(posedge host_clk);
    u_mon.check_value("core_reset_cycles", 32'd1, hif_pkg::data_t'(u_mon.rst_cycles));
    read_check("rst_in_count", 1, 2);
    read_check("rst_out_count", 1, 0);
    drain();

    u_mon.report();
    if (u_mon.total_errors() == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (NUM_TRANS * 80) @(posedge host_clk);
    $display("timeout, the tests did not finish in %0d cycles", NUM_TRANS * 80);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
